// ==== source/MemoryMapPkg.sv ====
package MemoryMapPkg;

	// Peripheral registers, matched on the full byte address
	localparam logic [31:0] SevenSegAddr = 32'd255;
	localparam logic [31:0] ResetAddrAddr = 32'd259;
	localparam logic [31:0] MsCounterAddr = 32'd267;
	localparam logic [31:0] UsCounterAddr = 32'd271;
	localparam logic [31:0] BufferCtrlAddr = 32'd275;

	// Main data RAM window, inclusive on both ends
	localparam logic [31:0] RamBase = 32'd1024;
	localparam logic [31:0] RamLast = 32'd65535;

	// The RAM index covers the whole 64 KiB space
	// so the window bytes map straight onto it
	localparam int RamWords = 16384;
	localparam int RamIndexBits = 14;

	// Boot address seen by the processor after reset
	localparam logic [31:0] ResetAddrInit = 32'h3FC;

	// Clock cycles per counter tick
	localparam int MsPrescale = 8333;
	localparam int UsPrescale = 8;

endpackage

// ==== source/BusAccessPkg.sv ====
package BusAccessPkg;

	localparam int WordBits = 32;
	localparam int ByteBits = 8;
	localparam int ByteLanes = 4;

	typedef logic [WordBits-1:0] busWord;

	// Access size of a load or store
	typedef enum logic [2:0] {
		ModeNone = 3'd0,
		ModeByte = 3'd1,
		ModeHalf = 3'd2,
		ModeWord = 3'd3
	} AccessMode;

	// Target chosen by the address decode
	typedef enum logic [2:0] {
		RegionNone = 3'd0,
		RegionSevenSeg = 3'd1,
		RegionResetAddr = 3'd2,
		RegionMsCounter = 3'd3,
		RegionUsCounter = 3'd4,
		RegionBufferCtrl = 3'd5,
		RegionRam = 3'd6
	} Region;

endpackage

// ==== source/StageIf.sv ====
`timescale 1ns/100ps

interface StageIf import BusAccessPkg::*; ();

	// One item at a time, tagged by valid
	logic valid;
	Region region;
	// Byte address of the access
	busWord wordAddr;
	// Store data going in, raw read word coming out of the access stage
	busWord data;
	logic write;
	AccessMode mode;
	logic unsignedLoad;

	modport up(
		output valid,
		output region,
		output wordAddr,
		output data,
		output write,
		output mode,
		output unsignedLoad
	);

	modport down(
		input valid,
		input region,
		input wordAddr,
		input data,
		input write,
		input mode,
		input unsignedLoad
	);

endinterface

// ==== source/DataRam.sv ====
`timescale 1ns/100ps

module DataRam import BusAccessPkg::*, MemoryMapPkg::*; (
	input logic clk,
	input logic enable,
	input logic write,
	input logic [RamIndexBits+1:0] byteAddr,
	input AccessMode mode,
	input busWord writeData,
	output busWord readData
);

	busWord mem [RamWords];

	logic [RamIndexBits-1:0] wordIndex;
	logic [ByteLanes-1:0] laneEnable;
	busWord alignedData;

	assign wordIndex = byteAddr[RamIndexBits+1:2];

	// Replicate the store data so every lane sees its own copy
	always_comb begin
		case (mode)
			ModeByte: begin
				laneEnable = ByteLanes'(1) << byteAddr[1:0];
				alignedData = {ByteLanes{writeData[ByteBits-1:0]}};
			end
			ModeHalf: begin
				laneEnable = byteAddr[1] ? 4'b1100 : 4'b0011;
				alignedData = {2{writeData[2*ByteBits-1:0]}};
			end
			ModeWord: begin
				laneEnable = '1;
				alignedData = writeData;
			end
			default: begin
				laneEnable = '0;
				alignedData = writeData;
			end
		endcase
	end

	// Read returns the word as it was before a same-cycle write
	always_ff @(posedge clk) begin
		if (enable) begin
			readData <= mem[wordIndex];
			if (write) begin
				for (int lane = 0; lane < ByteLanes; lane++) begin
					if (laneEnable[lane])
						mem[wordIndex][lane*ByteBits +: ByteBits] <=
							alignedData[lane*ByteBits +: ByteBits];
				end
			end
		end
	end

endmodule

// ==== source/RequestDecodeStage.sv ====
`timescale 1ns/100ps

module RequestDecodeStage import BusAccessPkg::*, MemoryMapPkg::*; (
	input logic clk,
	input logic rst,
	input logic cyc,
	input logic stb,
	input logic we,
	input busWord adr,
	input busWord datIn,
	input AccessMode mode,
	input logic unsignedLoad,
	input logic ack,
	StageIf.up decodeOut
);

	logic busy;
	logic accept;

	function automatic Region decodeRegion(input busWord address);
		Region result;
		if (address == SevenSegAddr)
			result = RegionSevenSeg;
		else if (address == ResetAddrAddr)
			result = RegionResetAddr;
		else if (address == MsCounterAddr)
			result = RegionMsCounter;
		else if (address == UsCounterAddr)
			result = RegionUsCounter;
		else if (address == BufferCtrlAddr)
			result = RegionBufferCtrl;
		else if (address >= RamBase && address <= RamLast)
			result = RegionRam;
		else
			result = RegionNone;
		return result;
	endfunction

	// A held request is taken once, then ignored until its ack is gone
	assign accept = cyc && stb && !busy && !ack;

	always_ff @(posedge clk or negedge rst) begin
		if (rst == 1'b0) begin
			busy <= 1'b0;
			decodeOut.valid <= 1'b0;
		end
		else begin
			decodeOut.valid <= accept;
			if (accept)
				busy <= 1'b1;
			else if (ack)
				busy <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			decodeOut.region <= decodeRegion(adr);
			decodeOut.wordAddr <= adr;
			decodeOut.data <= datIn;
			decodeOut.write <= we;
			decodeOut.mode <= mode;
			decodeOut.unsignedLoad <= unsignedLoad;
		end
	end

	// The stage stays busy until the ack of its item has fallen
	noRepeatAccept: assert property (@(posedge clk) disable iff (rst == 1'b0)
		decodeOut.valid |-> !$past(decodeOut.valid) && !$past(decodeOut.valid, 2) &&
			!$past(decodeOut.valid, 3));

endmodule

// ==== source/PeripheralAccessStage.sv ====
`timescale 1ns/100ps

module PeripheralAccessStage import BusAccessPkg::*, MemoryMapPkg::*; (
	input logic clk,
	input logic rst,
	input logic frameDone,
	StageIf.down decodeOut,
	StageIf.up accessOut,
	output busWord sevenSegment,
	output busWord resetAddress,
	output logic displayBuffer
);

	logic swapPending;
	logic regWrite;
	logic ramEnable;
	busWord ramReadData;
	busWord regReadData;
	busWord regData;

	logic [$clog2(MsPrescale)-1:0] msPre;
	logic [$clog2(UsPrescale)-1:0] usPre;
	busWord msCount;
	busWord usCount;

	assign regWrite = decodeOut.valid && decodeOut.write;
	assign ramEnable = decodeOut.valid && decodeOut.region == RegionRam;

	DataRam ram0 (
		.clk(clk),
		.enable(ramEnable),
		.write(decodeOut.write),
		.byteAddr(decodeOut.wordAddr[RamIndexBits+1:0]),
		.mode(decodeOut.mode),
		.writeData(decodeOut.data),
		.readData(ramReadData)
	);

	// Register writes and the deferred buffer swap
	always_ff @(posedge clk or negedge rst) begin
		if (rst == 1'b0) begin
			sevenSegment <= '0;
			resetAddress <= ResetAddrInit;
			displayBuffer <= 1'b0;
			swapPending <= 1'b0;
		end
		else begin
			// Swap only at the end of a displayed frame
			if (frameDone && swapPending) begin
				displayBuffer <= ~displayBuffer;
				swapPending <= 1'b0;
			end
			if (regWrite) begin
				case (decodeOut.region)
					RegionSevenSeg: sevenSegment <= decodeOut.data;
					RegionResetAddr: resetAddress <= decodeOut.data;
					RegionBufferCtrl: swapPending <= decodeOut.data[0];
					default: ;
				endcase
			end
		end
	end

	// Free-running time bases
	always_ff @(posedge clk or negedge rst) begin
		if (rst == 1'b0) begin
			msPre <= '0;
			msCount <= '0;
			usPre <= '0;
			usCount <= '0;
		end
		else begin
			if (msPre == MsPrescale - 1) begin
				msPre <= '0;
				msCount <= msCount + 1'b1;
			end
			else begin
				msPre <= msPre + 1'b1;
			end
			if (usPre == UsPrescale - 1) begin
				usPre <= '0;
				usCount <= usCount + 1'b1;
			end
			else begin
				usPre <= usPre + 1'b1;
			end
		end
	end

	always_comb begin
		case (decodeOut.region)
			RegionSevenSeg: regReadData = sevenSegment;
			RegionResetAddr: regReadData = resetAddress;
			RegionMsCounter: regReadData = msCount;
			RegionUsCounter: regReadData = usCount;
			RegionBufferCtrl: regReadData = busWord'(swapPending);
			default: regReadData = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (rst == 1'b0)
			accessOut.valid <= 1'b0;
		else
			accessOut.valid <= decodeOut.valid;
	end

	always_ff @(posedge clk) begin
		if (decodeOut.valid) begin
			accessOut.region <= decodeOut.region;
			accessOut.wordAddr <= decodeOut.wordAddr;
			accessOut.write <= decodeOut.write;
			accessOut.mode <= decodeOut.mode;
			accessOut.unsignedLoad <= decodeOut.unsignedLoad;
			regData <= regReadData;
		end
	end

	// RAM word arrives from its own output register in the same cycle
	assign accessOut.data = (accessOut.region == RegionRam) ? ramReadData : regData;

	legalRegion: assert property (@(posedge clk) disable iff (rst == 1'b0)
		decodeOut.valid |-> decodeOut.region inside {RegionNone, RegionSevenSeg,
			RegionResetAddr, RegionMsCounter, RegionUsCounter, RegionBufferCtrl, RegionRam});

endmodule

// ==== source/ResponseStage.sv ====
`timescale 1ns/100ps

module ResponseStage import BusAccessPkg::*; (
	input logic clk,
	input logic rst,
	StageIf.down accessOut,
	input busWord ramData,
	output busWord datOut,
	output logic ack
);

	busWord byteShifted;
	busWord halfShifted;
	logic [ByteBits-1:0] loadByte;
	logic [2*ByteBits-1:0] loadHalf;
	busWord result;

	// Bring the addressed lane down to bit 0
	assign byteShifted = ramData >> (ByteBits * accessOut.wordAddr[1:0]);
	assign halfShifted = ramData >> (2 * ByteBits * accessOut.wordAddr[1]);
	assign loadByte = byteShifted[ByteBits-1:0];
	assign loadHalf = halfShifted[2*ByteBits-1:0];

	always_comb begin
		result = '0;
		if (!accessOut.write && accessOut.region == RegionRam) begin
			case (accessOut.mode)
				ModeByte: result = {{(WordBits-ByteBits){loadByte[ByteBits-1] &
					~accessOut.unsignedLoad}}, loadByte};
				ModeHalf: result = {{(WordBits-2*ByteBits){loadHalf[2*ByteBits-1] &
					~accessOut.unsignedLoad}}, loadHalf};
				ModeWord: result = ramData;
				default: result = '0;
			endcase
		end
		else if (!accessOut.write && accessOut.region != RegionNone) begin
			// Registers and counters are always full words
			result = accessOut.data;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (rst == 1'b0)
			ack <= 1'b0;
		else
			ack <= accessOut.valid;
	end

	always_ff @(posedge clk) begin
		if (accessOut.valid)
			datOut <= result;
	end

	singleAck: assert property (@(posedge clk) disable iff (rst == 1'b0)
		ack |=> !ack);

	// A new item never arrives while the previous ack is still out
	ackBeforeNext: assert property (@(posedge clk) disable iff (rst == 1'b0)
		accessOut.valid |-> !ack);

endmodule

// ==== source/MemorySubsystem.sv ====
`timescale 1ns/100ps

module MemorySubsystem import BusAccessPkg::*; (
	input logic clk,
	input logic rst,

	// Wishbone classic slave
	input logic cyc,
	input logic stb,
	input logic we,
	input busWord adr,
	input busWord datIn,
	input AccessMode mode,
	input logic unsignedLoad,
	output busWord datOut,
	output logic ack,

	// Display side
	input logic frameDone,
	output busWord sevenSegment,
	output busWord resetAddress,
	output logic displayBuffer
);

	StageIf decodeOutIf ();
	StageIf accessOutIf ();

	RequestDecodeStage decode0 (
		.clk(clk),
		.rst(rst),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.datIn(datIn),
		.mode(mode),
		.unsignedLoad(unsignedLoad),
		.ack(ack),
		.decodeOut(decodeOutIf.up)
	);

	PeripheralAccessStage access0 (
		.clk(clk),
		.rst(rst),
		.frameDone(frameDone),
		.decodeOut(decodeOutIf.down),
		.accessOut(accessOutIf.up),
		.sevenSegment(sevenSegment),
		.resetAddress(resetAddress),
		.displayBuffer(displayBuffer)
	);

	// The access stage places the raw RAM word on its data field
	ResponseStage response0 (
		.clk(clk),
		.rst(rst),
		.accessOut(accessOutIf.down),
		.ramData(accessOutIf.data),
		.datOut(datOut),
		.ack(ack)
	);

endmodule

// ==== bench/ClockGen.sv ====
`timescale 1ns/100ps

module ClockGen (
	output logic clk,
	output logic rst
);

	localparam int HalfPeriod = 4;
	localparam int ResetCycles = 3;

	initial begin
		clk = 1'b0;
		forever #HalfPeriod clk = ~clk;
	end

	// Release just after an edge, like the rest of the stimulus
	initial begin
		rst = 1'b0;
		repeat (ResetCycles) @(posedge clk);
		#1 rst = 1'b1;
	end

endmodule

// ==== bench/MemorySubsystemTb.sv ====
`timescale 1ns/100ps

module MemorySubsystemTb import BusAccessPkg::*, MemoryMapPkg::*; ();

	localparam int DriveDelay = 1;
	localparam int AckLimit = 16;
	localparam int RandomSeed = 64570;
	localparam int RandomWords = 32;
	localparam int LaneWords = 4;
	// Transactions of the reset, word RAM, lane, register, counter, swap and unmapped tests
	localparam int TxnCount = 2 + 2 * RandomWords + 25 * LaneWords + 12 + 7 + 4 + 8;
	localparam int TimeoutCycles = TxnCount * 10 + 20000;

	logic clk;
	logic rst;
	logic cyc;
	logic stb;
	logic we;
	busWord adr;
	busWord datIn;
	AccessMode mode;
	logic unsignedLoad;
	busWord datOut;
	logic ack;
	logic frameDone;
	busWord sevenSegment;
	busWord resetAddress;
	logic displayBuffer;

	int cycleCount = 0;
	logic [7:0] shadowRam [65536];
	busWord shadowSevenSeg;
	busWord shadowResetAddr;
	logic shadowPending;
	logic shadowDisplay;
	busWord gotQ[$];
	busWord expQ[$];
	string tagQ[$];

	ClockGen clockGen0 (.clk(clk), .rst(rst));

	MemorySubsystem dut0 (
		.clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr), .datIn(datIn),
		.mode(mode), .unsignedLoad(unsignedLoad), .datOut(datOut), .ack(ack),
		.frameDone(frameDone), .sevenSegment(sevenSegment), .resetAddress(resetAddress),
		.displayBuffer(displayBuffer)
	);

	always @(posedge clk) cycleCount <= cycleCount + 1;

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic checkWord(input busWord got, input busWord expected, input string what);
		if (got !== expected)
			abortRun($sformatf("FAIL %0t: %s got %h expected %h", $time, what, got, expected));
	endtask

	task automatic checkBit(input logic got, input logic expected, input string what);
		if (got !== expected)
			abortRun($sformatf("FAIL %0t: %s got %b expected %b", $time, what, got, expected));
	endtask

	// Expected load result from the map rules and the shadow state
	function automatic busWord expectedRead(input busWord address, input AccessMode accessMode,
			input logic unsignedFlag);
		logic [15:0] base;
		logic [7:0] loadByte;
		logic [15:0] loadHalf;
		base = {address[15:2], 2'b00};
		if (address == SevenSegAddr)
			return shadowSevenSeg;
		if (address == ResetAddrAddr)
			return shadowResetAddr;
		if (address == BufferCtrlAddr)
			return {31'b0, shadowPending};
		if (address < RamBase || address > RamLast)
			return '0;
		loadByte = shadowRam[address[15:0]];
		loadHalf = {shadowRam[base + 2 * address[1] + 1], shadowRam[base + 2 * address[1]]};
		case (accessMode)
			ModeByte: return unsignedFlag ? {24'b0, loadByte} : {{24{loadByte[7]}}, loadByte};
			ModeHalf: return unsignedFlag ? {16'b0, loadHalf} : {{16{loadHalf[15]}}, loadHalf};
			ModeWord: return {shadowRam[base + 3], shadowRam[base + 2], shadowRam[base + 1],
				shadowRam[base]};
			default: return '0;
		endcase
	endfunction

	function automatic void updateShadow(input busWord address, input AccessMode accessMode,
			input busWord data);
		logic [15:0] base;
		base = {address[15:2], 2'b00};
		if (address == SevenSegAddr)
			shadowSevenSeg = data;
		else if (address == ResetAddrAddr)
			shadowResetAddr = data;
		else if (address == BufferCtrlAddr)
			shadowPending = data[0];
		else if (address >= RamBase && address <= RamLast) begin
			if (accessMode == ModeByte)
				shadowRam[address[15:0]] = data[7:0];
			else if (accessMode == ModeHalf)
				{shadowRam[base + 2 * address[1] + 1], shadowRam[base + 2 * address[1]]} = data[15:0];
			else if (accessMode == ModeWord)
				{shadowRam[base + 3], shadowRam[base + 2], shadowRam[base + 1], shadowRam[base]} = data;
		end
	endfunction

	// One Wishbone classic cycle returning the data and the sampling cycle
	task automatic busAccess(input logic write, input busWord address, input busWord data,
			input AccessMode accessMode, input logic unsignedFlag, output busWord readData,
			output int sampleCycle);
		int edges;
		@(posedge clk);
		#DriveDelay;
		cyc = 1'b1;
		stb = 1'b1;
		we = write;
		adr = address;
		datIn = data;
		mode = accessMode;
		unsignedLoad = unsignedFlag;
		edges = 0;
		sampleCycle = 0;
		do begin
			@(posedge clk);
			#DriveDelay;
			edges++;
			if (edges == 1)
				sampleCycle = cycleCount;
		end while (!ack && edges < AckLimit);
		if (!ack)
			abortRun($sformatf("No ack for the access to address %0d", address));
		checkBit(edges == 3, 1'b1, "ack two edges after the sampling edge");
		readData = datOut;
		@(posedge clk);
		#DriveDelay;
		checkBit(ack, 1'b0, "ack lasting one cycle");
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
	endtask

	task automatic writeBus(input busWord address, input AccessMode accessMode, input busWord data);
		busWord unused;
		int cycleAt;
		busAccess(1'b1, address, data, accessMode, 1'b0, unused, cycleAt);
		updateShadow(address, accessMode, data);
	endtask

	task automatic readCheck(input busWord address, input AccessMode accessMode,
			input logic unsignedFlag);
		busWord got;
		int cycleAt;
		busAccess(1'b0, address, '0, accessMode, unsignedFlag, got, cycleAt);
		expQ.push_back(expectedRead(address, accessMode, unsignedFlag));
		tagQ.push_back($sformatf("read of %0d as %s unsigned %b", address, accessMode.name(),
			unsignedFlag));
		gotQ.push_back(got);
	endtask

	// Two reads span cycles apart must differ by floor or ceiling of span over prescale
	task automatic checkCounterRate(input busWord address, input int prescale,
			input int waitCycles, input logic writeBetween);
		busWord first;
		busWord second;
		busWord unused;
		int firstCycle;
		int secondCycle;
		int span;
		busAccess(1'b0, address, '0, ModeWord, 1'b0, first, firstCycle);
		if (writeBetween)
			busAccess(1'b1, address, 32'hFFFF0000, ModeWord, 1'b0, unused, secondCycle);
		repeat (waitCycles) @(posedge clk);
		busAccess(1'b0, address, '0, ModeWord, 1'b0, second, secondCycle);
		span = secondCycle - firstCycle;
		checkBit((second - first) == span / prescale ||
			(second - first) == (span + prescale - 1) / prescale, 1'b1,
			$sformatf("counter %0d step %0d over %0d cycles", address, second - first, span));
	endtask

	task automatic pulseFrameDone();
		@(posedge clk);
		#DriveDelay;
		frameDone = 1'b1;
		@(posedge clk);
		#DriveDelay;
		frameDone = 1'b0;
		if (shadowPending) begin
			shadowDisplay = ~shadowDisplay;
			shadowPending = 1'b0;
		end
	endtask

	function automatic busWord randomRamWord();
		return RamBase + busWord'(($urandom % ((RamLast - RamBase + 1) / ByteLanes)) * ByteLanes);
	endfunction

	initial begin : compareProcess
		forever begin
			wait (gotQ.size() != 0);
			checkWord(gotQ.pop_front(), expQ.pop_front(), tagQ.pop_front());
		end
	end

	initial begin : watchdog
		repeat (TimeoutCycles) @(posedge clk);
		$display("Timeout after %0d cycles, the test did not finish", TimeoutCycles);
		$display("*** TEST FAILED ***");
		$fatal(1, "watchdog expired");
	end

	initial begin : stimulus
		busWord addrList[$];
		busWord base;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		datIn = '0;
		mode = ModeNone;
		unsignedLoad = 1'b0;
		frameDone = 1'b0;
		shadowSevenSeg = '0;
		shadowResetAddr = 32'h3FC;
		shadowPending = 1'b0;
		shadowDisplay = 1'b0;
		void'($urandom(RandomSeed));
		wait (rst === 1'b1);

		// Reset values and word RAM
		readCheck(SevenSegAddr, ModeWord, 1'b0);
		readCheck(ResetAddrAddr, ModeWord, 1'b0);
		checkWord(sevenSegment, shadowSevenSeg, "sevenSegment port after reset");
		checkWord(resetAddress, shadowResetAddr, "resetAddress port after reset");
		checkBit(displayBuffer, shadowDisplay, "displayBuffer after reset");
		repeat (RandomWords) begin
			addrList.push_back(randomRamWord());
			writeBus(addrList[$], ModeWord, $urandom);
		end
		foreach (addrList[i])
			readCheck(addrList[i], ModeWord, 1'b0);

		// Byte and half lanes with a forced negative byte and half
		for (int w = 0; w < LaneWords; w++) begin
			base = randomRamWord();
			writeBus(base, ModeWord, $urandom);
			for (int lane = 0; lane < ByteLanes; lane++) begin
				writeBus(base + lane, ModeByte, (lane == 1) ? 32'h80 : $urandom);
				readCheck(base, ModeWord, 1'b0);
				readCheck(base + lane, ModeByte, 1'b0);
				readCheck(base + lane, ModeByte, 1'b1);
			end
			for (int half = 0; half < 2; half++) begin
				writeBus(base + 2 * half, ModeHalf, (half == 1) ? 32'h8001 : $urandom);
				readCheck(base, ModeWord, 1'b0);
				readCheck(base + 2 * half, ModeHalf, 1'b0);
				readCheck(base + 2 * half, ModeHalf, 1'b1);
			end
		end

		// Peripheral registers
		repeat (3) begin
			writeBus(SevenSegAddr, ModeWord, $urandom);
			writeBus(ResetAddrAddr, ModeWord, $urandom);
			checkWord(sevenSegment, shadowSevenSeg, "sevenSegment port");
			checkWord(resetAddress, shadowResetAddr, "resetAddress port");
			readCheck(SevenSegAddr, ModeWord, 1'b0);
			readCheck(ResetAddrAddr, ModeWord, 1'b0);
		end

		// Counters with an ignored write in the second run
		checkCounterRate(UsCounterAddr, UsPrescale, 20 + $urandom % 80, 1'b0);
		checkCounterRate(UsCounterAddr, UsPrescale, 40, 1'b1);
		checkCounterRate(MsCounterAddr, MsPrescale, MsPrescale + 700, 1'b0);

		// Buffer swap waits for the end of a frame
		writeBus(BufferCtrlAddr, ModeWord, 32'h1);
		readCheck(BufferCtrlAddr, ModeWord, 1'b0);
		checkBit(displayBuffer, shadowDisplay, "displayBuffer before frameDone");
		pulseFrameDone();
		checkBit(displayBuffer, shadowDisplay, "displayBuffer after swap");
		readCheck(BufferCtrlAddr, ModeWord, 1'b0);
		pulseFrameDone();
		checkBit(displayBuffer, shadowDisplay, "displayBuffer with nothing pending");
		readCheck(BufferCtrlAddr, ModeWord, 1'b0);

		// Unmapped address 70000 aliases RAM byte 4464 under a partial decode
		writeBus(4464, ModeWord, 32'h13579BDF);
		readCheck(300, ModeWord, 1'b0);
		readCheck(70000, ModeWord, 1'b0);
		writeBus(300, ModeWord, 32'hDEADBEEF);
		writeBus(70000, ModeWord, 32'hCAFEF00D);
		readCheck(SevenSegAddr, ModeWord, 1'b0);
		readCheck(ResetAddrAddr, ModeWord, 1'b0);
		readCheck(4464, ModeWord, 1'b0);
		checkWord(sevenSegment, shadowSevenSeg, "sevenSegment port after unmapped writes");

		wait (gotQ.size() == 0);
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// ==== build.f ====
source/MemoryMapPkg.sv
source/BusAccessPkg.sv
source/StageIf.sv
source/DataRam.sv
source/RequestDecodeStage.sv
source/PeripheralAccessStage.sv
source/ResponseStage.sv
source/MemorySubsystem.sv
bench/ClockGen.sv
bench/MemorySubsystemTb.sv

// ==== Bender.yml ====
package:
  name: memory_subsystem

sources:
  - source/MemoryMapPkg.sv
  - source/BusAccessPkg.sv
  - source/StageIf.sv
  - source/DataRam.sv
  - source/RequestDecodeStage.sv
  - source/PeripheralAccessStage.sv
  - source/ResponseStage.sv
  - source/MemorySubsystem.sv
  - target: test
    files:
      - bench/ClockGen.sv
      - bench/MemorySubsystemTb.sv
